// File: br_macros.svh
`ifndef BR_MACROS_SVH
`define BR_MACROS_SVH

// Reorder buffer sizing
`define ROB_IDX_W 5      // Bits per ROB index
`define ROB_DEPTH 32     // Entries, always 2**ROB_IDX_W

// Clock-to-output delay on register updates
`define SD #1

// Opcodes that bypass the condition test
`define BR_INST  6'h30   // Unconditional branch
`define BSR_INST 6'h34   // Branch to subroutine
`define JMP_GRP  6'h1a   // JMP, JSR, RET, JSR_CO share this opcode

// Conditional integer branches occupy 6'h38 to 6'h3f
// Low three opcode bits select the br_func_e test

`endif

// File: br_pkg.sv
`include "br_macros.svh"

package br_pkg;

	// Branch format, PC-relative displacement
	typedef struct packed
	{
		logic [5:0]         opcode;  // Major opcode
		logic [4:0]         ra;      // Tested register, or link register
		logic signed [20:0] disp;    // Word displacement
	} br_fmt_t;

	// Memory-jump format, target comes from rb
	typedef struct packed
	{
		logic [5:0]  opcode;  // Always JMP_GRP
		logic [4:0]  ra;      // Link register
		logic [4:0]  rb;      // Holds the target address
		logic [1:0]  jfunc;   // JMP, JSR, RET or JSR_CO
		logic [13:0] hint;    // Prediction hint only
	} jmp_fmt_t;

	// One instruction word, read through either view
	typedef union packed
	{
		br_fmt_t  br;
		jmp_fmt_t jmp;
	} br_inst_u;

	// Condition select, bit 2 inverts the base test
	typedef enum logic [2:0]
	{
		LBC = 3'b000,  // Low bit clear
		EQ  = 3'b001,  // Equal to zero
		LT  = 3'b010,  // Negative
		LE  = 3'b011,  // Negative or zero
		LBS = 3'b100,  // Low bit set
		NE  = 3'b101,  // Non-zero
		GE  = 3'b110,  // Zero or positive
		GT  = 3'b111   // Strictly positive
	} br_func_e;

endpackage

// File: brcond.sv
`timescale 1ns/100ps

module brcond
	import br_pkg::*;
(
	input  logic [63:0] opa_i,   // Register A value
	input  br_func_e    func_i,  // Which test to apply
	output logic        cond_o   // Test result
);

	logic is_zero;
	logic is_neg;
	logic base;

	assign is_zero = (opa_i == 64'd0);
	assign is_neg  = opa_i[63];  // Sign bit

	// Four base tests, the other four are their inverses
	always_comb
	begin
		case (func_i[1:0])
			2'b00: base = ~opa_i[0];         // Low bit clear
			2'b01: base = is_zero;
			2'b10: base = is_neg;
			2'b11: base = is_neg | is_zero;  // Non-positive
			default: base = 1'b0;
		endcase
	end

	// LBS, NE, GE, GT
	assign cond_o = base ^ func_i[2];

endmodule

// File: br_alu.sv
`timescale 1ns/100ps
`include "br_macros.svh"

module br_alu
	import br_pkg::*;
(
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  start_i,      // One branch this cycle
	input  br_inst_u              inst_i,       // Instruction word
	input  logic [63:0]           npc_i,        // PC of the next instruction
	input  logic [63:0]           opa_i,        // Register A value
	input  logic [63:0]           opb_i,        // Register B value
	input  logic [`ROB_IDX_W-1:0] rob_idx_i,
	output logic                  done_o,
	output logic                  br_taken_o,
	output logic [63:0]           br_target_o,
	output logic [`ROB_IDX_W-1:0] rob_idx_o,
	output logic [63:0]           br_pc_o       // Fall-through PC
);

	logic        is_jmp;
	logic        is_uncond;
	logic        cond_true;
	logic [63:0] br_disp;
	logic        taken_nxt;
	logic [63:0] target_nxt;

	// Jump group is read through the memory-jump view
	assign is_jmp    = (inst_i.jmp.opcode == `JMP_GRP);
	assign is_uncond = (inst_i.br.opcode == `BR_INST) || (inst_i.br.opcode == `BSR_INST);

	// Word displacement to byte offset
	assign br_disp = {{41{inst_i.br.disp[20]}}, inst_i.br.disp, 2'b00};

	// Low opcode bits pick the test on register A
	brcond u_brcond
	(
		.opa_i  (opa_i),
		.func_i (br_func_e'(inst_i.br.opcode[2:0])),
		.cond_o (cond_true)
	);

	always_comb
	begin
		if (is_jmp)
		begin
			target_nxt = {opb_i[63:2], 2'b00};  // Register target, word aligned
			taken_nxt  = 1'b1;
		end
		else if (is_uncond)
		begin
			target_nxt = npc_i + br_disp;
			taken_nxt  = 1'b1;  // BR and BSR always go
		end
		else
		begin
			target_nxt = npc_i + br_disp;
			taken_nxt  = cond_true;
		end
	end

	// Single result stage
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			done_o      <= `SD 1'b0;
			br_taken_o  <= `SD 1'b0;
			br_target_o <= `SD 64'd0;
			rob_idx_o   <= `SD '0;
			br_pc_o     <= `SD 64'd0;
		end
		else
		begin
			done_o <= `SD start_i;  // Strobe passes straight through
			if (start_i)
			begin
				br_taken_o  <= `SD taken_nxt;
				br_target_o <= `SD target_nxt;
				rob_idx_o   <= `SD rob_idx_i;
				br_pc_o     <= `SD npc_i;
			end
		end
	end

endmodule

// File: br_resolve.sv
`timescale 1ns/100ps
`include "br_macros.svh"

module br_resolve
(
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  start_i,        // Same strobe the ALU sees
	input  logic                  pred_taken_i,   // Front-end direction
	input  logic [63:0]           pred_target_i,  // Front-end target
	input  logic                  done_i,         // ALU result valid
	input  logic                  taken_i,
	input  logic [63:0]           target_i,
	input  logic [63:0]           npc_i,          // Fall-through from the ALU
	input  logic [`ROB_IDX_W-1:0] rob_idx_i,
	output logic                  valid_o,
	output logic                  taken_o,
	output logic                  mispredict_o,
	output logic [63:0]           next_pc_o,      // Correct next PC
	output logic [`ROB_IDX_W-1:0] rob_idx_o
);

	logic        pred_taken_q;
	logic [63:0] pred_target_q;
	logic        mis_nxt;
	logic [63:0] next_pc_nxt;

	// Prediction held one stage so it meets the ALU result
	always_ff @(posedge clk)
	begin
		if (start_i)
		begin
			pred_taken_q  <= `SD pred_taken_i;
			pred_target_q <= `SD pred_target_i;
		end
	end

	// Wrong direction, or right direction with a wrong target
	assign mis_nxt = done_i &&
		((taken_i != pred_taken_q) || (taken_i && (target_i != pred_target_q)));

	assign next_pc_nxt = taken_i ? target_i : npc_i;

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			valid_o      <= `SD 1'b0;
			taken_o      <= `SD 1'b0;
			mispredict_o <= `SD 1'b0;
			next_pc_o    <= `SD 64'd0;
			rob_idx_o    <= `SD '0;
		end
		else
		begin
			valid_o      <= `SD done_i;
			taken_o      <= `SD done_i & taken_i;  // Quiet when idle
			mispredict_o <= `SD mis_nxt;
			if (done_i)
			begin
				next_pc_o <= `SD next_pc_nxt;
				rob_idx_o <= `SD rob_idx_i;
			end
		end
	end

endmodule

// File: br_redirect.sv
`timescale 1ns/100ps
`include "br_macros.svh"

module br_redirect
(
	input  logic                  clk,
	input  logic                  rst,
	input  logic [`ROB_IDX_W-1:0] rob_head_i,         // Oldest ROB entry
	input  logic                  val0_i,             // Lane 0 resolved
	input  logic                  mis0_i,
	input  logic [63:0]           pc0_i,
	input  logic [`ROB_IDX_W-1:0] rob0_i,
	input  logic                  val1_i,             // Lane 1 resolved
	input  logic                  mis1_i,
	input  logic [63:0]           pc1_i,
	input  logic [`ROB_IDX_W-1:0] rob1_i,
	output logic                  redirect_valid_o,
	output logic [63:0]           redirect_pc_o,
	output logic [`ROB_IDX_W-1:0] redirect_rob_idx_o
);

	logic                  cand0;
	logic                  cand1;
	logic [`ROB_IDX_W-1:0] age0;
	logic [`ROB_IDX_W-1:0] age1;
	logic                  pick1;

	assign cand0 = val0_i & mis0_i;
	assign cand1 = val1_i & mis1_i;

	// Distance from head, wraps around the ring
	assign age0 = `ROB_IDX_W'((`ROB_DEPTH + rob0_i - rob_head_i) % `ROB_DEPTH);
	assign age1 = `ROB_IDX_W'((`ROB_DEPTH + rob1_i - rob_head_i) % `ROB_DEPTH);

	// Lane 1 only when alone or strictly older
	// Equal ages cannot happen, lanes never share an index
	assign pick1 = cand1 & (~cand0 | (age1 < age0));

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			redirect_valid_o   <= `SD 1'b0;
			redirect_pc_o      <= `SD 64'd0;
			redirect_rob_idx_o <= `SD '0;
		end
		else
		begin
			redirect_valid_o <= `SD cand0 | cand1;
			if (cand0 | cand1)
			begin
				redirect_pc_o      <= `SD pick1 ? pc1_i : pc0_i;
				redirect_rob_idx_o <= `SD pick1 ? rob1_i : rob0_i;
			end
		end
	end

endmodule

// File: br_unit.sv
`timescale 1ns/100ps
`include "br_macros.svh"

module br_unit
	import br_pkg::*;
(
	input  logic                  clk,
	input  logic                  rst,
	input  logic [`ROB_IDX_W-1:0] rob_head_i,
	// Lane 0 issue
	input  logic                  start0_i,
	input  br_inst_u              inst0_i,
	input  logic [63:0]           npc0_i,
	input  logic [63:0]           opa0_i,
	input  logic [63:0]           opb0_i,
	input  logic [`ROB_IDX_W-1:0] rob_idx0_i,
	input  logic                  pred_taken0_i,
	input  logic [63:0]           pred_target0_i,
	// Lane 1 issue
	input  logic                  start1_i,
	input  br_inst_u              inst1_i,
	input  logic [63:0]           npc1_i,
	input  logic [63:0]           opa1_i,
	input  logic [63:0]           opb1_i,
	input  logic [`ROB_IDX_W-1:0] rob_idx1_i,
	input  logic                  pred_taken1_i,
	input  logic [63:0]           pred_target1_i,
	// Resolved, cycle 2
	output logic                  valid0_o,
	output logic                  taken0_o,
	output logic                  mispredict0_o,
	output logic [63:0]           next_pc0_o,
	output logic [`ROB_IDX_W-1:0] rob_idx0_o,
	output logic                  valid1_o,
	output logic                  taken1_o,
	output logic                  mispredict1_o,
	output logic [63:0]           next_pc1_o,
	output logic [`ROB_IDX_W-1:0] rob_idx1_o,
	// Redirect, cycle 3
	output logic                  redirect_valid_o,
	output logic [63:0]           redirect_pc_o,
	output logic [`ROB_IDX_W-1:0] redirect_rob_idx_o
);

	logic                  alu_done0, alu_done1;
	logic                  alu_taken0, alu_taken1;
	logic [63:0]           alu_target0, alu_target1;
	logic [`ROB_IDX_W-1:0] alu_rob0, alu_rob1;
	logic [63:0]           alu_pc0, alu_pc1;

	br_alu u_alu0
	(
		.clk(clk), .rst(rst), .start_i(start0_i), .inst_i(inst0_i),
		.npc_i(npc0_i), .opa_i(opa0_i), .opb_i(opb0_i), .rob_idx_i(rob_idx0_i),
		.done_o(alu_done0), .br_taken_o(alu_taken0), .br_target_o(alu_target0),
		.rob_idx_o(alu_rob0), .br_pc_o(alu_pc0)
	);

	br_alu u_alu1
	(
		.clk(clk), .rst(rst), .start_i(start1_i), .inst_i(inst1_i),
		.npc_i(npc1_i), .opa_i(opa1_i), .opb_i(opb1_i), .rob_idx_i(rob_idx1_i),
		.done_o(alu_done1), .br_taken_o(alu_taken1), .br_target_o(alu_target1),
		.rob_idx_o(alu_rob1), .br_pc_o(alu_pc1)
	);

	br_resolve u_res0
	(
		.clk(clk), .rst(rst), .start_i(start0_i),
		.pred_taken_i(pred_taken0_i), .pred_target_i(pred_target0_i),
		.done_i(alu_done0), .taken_i(alu_taken0), .target_i(alu_target0),
		.npc_i(alu_pc0), .rob_idx_i(alu_rob0),
		.valid_o(valid0_o), .taken_o(taken0_o), .mispredict_o(mispredict0_o),
		.next_pc_o(next_pc0_o), .rob_idx_o(rob_idx0_o)
	);

	br_resolve u_res1
	(
		.clk(clk), .rst(rst), .start_i(start1_i),
		.pred_taken_i(pred_taken1_i), .pred_target_i(pred_target1_i),
		.done_i(alu_done1), .taken_i(alu_taken1), .target_i(alu_target1),
		.npc_i(alu_pc1), .rob_idx_i(alu_rob1),
		.valid_o(valid1_o), .taken_o(taken1_o), .mispredict_o(mispredict1_o),
		.next_pc_o(next_pc1_o), .rob_idx_o(rob_idx1_o)
	);

	// Oldest mispredict of the two lanes
	br_redirect u_redirect
	(
		.clk(clk), .rst(rst), .rob_head_i(rob_head_i),
		.val0_i(valid0_o), .mis0_i(mispredict0_o), .pc0_i(next_pc0_o), .rob0_i(rob_idx0_o),
		.val1_i(valid1_o), .mis1_i(mispredict1_o), .pc1_i(next_pc1_o), .rob1_i(rob_idx1_o),
		.redirect_valid_o(redirect_valid_o), .redirect_pc_o(redirect_pc_o),
		.redirect_rob_idx_o(redirect_rob_idx_o)
	);

endmodule

// File: tb_br_unit.sv
`timescale 1ns/100ps
`include "br_macros.svh"

module tb_br_unit;

	localparam int PIPE_LEN    = 20;  // Back-to-back issue cycles
	// Cycle budget of reset and of each test in order
	localparam int TEST_CYCLES = 6 + 48*4 + 9*4 + 5*4 + 5*4 + (PIPE_LEN + 2) + 11;
	localparam int LIMIT_NS    = TEST_CYCLES * 4 + 400;

	logic                  clk;
	logic                  rst;
	logic [`ROB_IDX_W-1:0] rob_head_i;
	logic                  start0_i, start1_i;
	logic [31:0]           inst0_i, inst1_i;
	logic [63:0]           npc0_i, npc1_i;
	logic [63:0]           opa0_i, opa1_i;
	logic [63:0]           opb0_i, opb1_i;
	logic [`ROB_IDX_W-1:0] rob_idx0_i, rob_idx1_i;
	logic                  pred_taken0_i, pred_taken1_i;
	logic [63:0]           pred_target0_i, pred_target1_i;
	logic                  valid0_o, valid1_o;
	logic                  taken0_o, taken1_o;
	logic                  mispredict0_o, mispredict1_o;
	logic [63:0]           next_pc0_o, next_pc1_o;
	logic [`ROB_IDX_W-1:0] rob_idx0_o, rob_idx1_o;
	logic                  redirect_valid_o;
	logic [63:0]           redirect_pc_o;
	logic [`ROB_IDX_W-1:0] redirect_rob_idx_o;

	// Pending branch per lane
	logic                  l_en   [2];
	logic [31:0]           l_inst [2];
	logic [63:0]           l_npc  [2];
	logic [63:0]           l_opa  [2];
	logic [63:0]           l_opb  [2];
	logic [`ROB_IDX_W-1:0] l_rob  [2];
	logic                  l_pt   [2];  // Predicted taken
	logic [63:0]           l_ptg  [2];  // Predicted target

	// Expected results of the pipelined run
	logic                  e_tk  [2][PIPE_LEN];
	logic                  e_mis [2][PIPE_LEN];
	logic [63:0]           e_pc  [2][PIPE_LEN];
	logic [`ROB_IDX_W-1:0] e_rob [2][PIPE_LEN];

	int checks;
	int errors;
	int chk_mark;
	int err_mark;
	int seed_val;

	br_unit DUT
	(
		.clk(clk), .rst(rst), .rob_head_i(rob_head_i),
		.start0_i(start0_i), .inst0_i(inst0_i), .npc0_i(npc0_i),
		.opa0_i(opa0_i), .opb0_i(opb0_i), .rob_idx0_i(rob_idx0_i),
		.pred_taken0_i(pred_taken0_i), .pred_target0_i(pred_target0_i),
		.start1_i(start1_i), .inst1_i(inst1_i), .npc1_i(npc1_i),
		.opa1_i(opa1_i), .opb1_i(opb1_i), .rob_idx1_i(rob_idx1_i),
		.pred_taken1_i(pred_taken1_i), .pred_target1_i(pred_target1_i),
		.valid0_o(valid0_o), .taken0_o(taken0_o), .mispredict0_o(mispredict0_o),
		.next_pc0_o(next_pc0_o), .rob_idx0_o(rob_idx0_o),
		.valid1_o(valid1_o), .taken1_o(taken1_o), .mispredict1_o(mispredict1_o),
		.next_pc1_o(next_pc1_o), .rob_idx1_o(rob_idx1_o),
		.redirect_valid_o(redirect_valid_o), .redirect_pc_o(redirect_pc_o),
		.redirect_rob_idx_o(redirect_rob_idx_o)
	);

	always #2 clk = ~clk;  // 4 ns period

	function automatic logic [63:0] rand64();
		return {$urandom, $urandom};
	endfunction

	// Direction from the opcode class and the Alpha condition names
	function automatic logic ref_taken(input logic [31:0] inst, input logic [63:0] opa);
		logic [5:0]         op;
		logic signed [63:0] sv;
		op = inst[31:26];
		sv = opa;
		if (op == `BR_INST || op == `BSR_INST || op == `JMP_GRP)
			return 1'b1;
		case (op[2:0])
			3'd0: return opa[0] == 1'b0;  // BLBC
			3'd1: return sv == 0;         // BEQ
			3'd2: return sv < 0;          // BLT
			3'd3: return sv <= 0;         // BLE
			3'd4: return opa[0] == 1'b1;  // BLBS
			3'd5: return sv != 0;         // BNE
			3'd6: return sv >= 0;         // BGE
			default: return sv > 0;       // BGT
		endcase
	endfunction

	function automatic logic [63:0] ref_target(input logic [31:0] inst, input logic [63:0] npc,
		input logic [63:0] opb);
		logic signed [63:0] disp;
		disp = $signed(inst[20:0]);  // Sign-extended word count
		if (inst[31:26] == `JMP_GRP)
			return opb & ~64'h3;
		return npc + (disp <<< 2);
	endfunction

	function automatic logic ref_mispredict(input logic tk, input logic [63:0] tgt,
		input logic pt, input logic [63:0] ptg);
		return (tk != pt) || (tk && (tgt != ptg));
	endfunction

	// Distance from the ROB head where smaller means older
	function automatic int rob_age(input logic [`ROB_IDX_W-1:0] rob,
		input logic [`ROB_IDX_W-1:0] head);
		return (int'(rob) + `ROB_DEPTH - int'(head)) % `ROB_DEPTH;
	endfunction

	task automatic compare(input string name, input logic [63:0] exp, input logic [63:0] act);
		checks++;
		if (act !== exp)
		begin
			errors++;
			$display("Error at %0t ns: %s expected %h, got %h", $time, name, exp, act);
		end
	endtask

	task automatic end_test(input string name);
		$display("%s: %0d checks, %0d errors", name, checks - chk_mark, errors - err_mark);
		chk_mark = checks;
		err_mark = errors;
	endtask

	task automatic set_lane(input int lane, input logic [31:0] inst, input logic [63:0] npc,
		input logic [63:0] opa, input logic [63:0] opb, input logic [`ROB_IDX_W-1:0] rob,
		input logic pt, input logic [63:0] ptg);
		l_en[lane]   = 1'b1;
		l_inst[lane] = inst;
		l_npc[lane]  = npc;
		l_opa[lane]  = opa;
		l_opb[lane]  = opb;
		l_rob[lane]  = rob;
		l_pt[lane]   = pt;
		l_ptg[lane]  = ptg;
	endtask

	task automatic clear_lanes();
		for (int l = 0; l < 2; l++)
		begin
			l_en[l]   = 1'b0;
			l_inst[l] = '0;
			l_npc[l]  = '0;
			l_opa[l]  = '0;
			l_opb[l]  = '0;
			l_rob[l]  = '0;
			l_pt[l]   = 1'b0;
			l_ptg[l]  = '0;
		end
	endtask

	task automatic drive_lanes();
		start0_i       = l_en[0];
		inst0_i        = l_inst[0];
		npc0_i         = l_npc[0];
		opa0_i         = l_opa[0];
		opb0_i         = l_opb[0];
		rob_idx0_i     = l_rob[0];
		pred_taken0_i  = l_pt[0];
		pred_target0_i = l_ptg[0];
		start1_i       = l_en[1];
		inst1_i        = l_inst[1];
		npc1_i         = l_npc[1];
		opa1_i         = l_opa[1];
		opb1_i         = l_opb[1];
		rob_idx1_i     = l_rob[1];
		pred_taken1_i  = l_pt[1];
		pred_target1_i = l_ptg[1];
	endtask

	// Expected verdict for the pending branch of one lane
	task automatic model_lane(input int l, output logic tk, output logic mis,
		output logic [63:0] pc);
		logic [63:0] tgt;
		tgt = ref_target(l_inst[l], l_npc[l], l_opb[l]);
		tk  = ref_taken(l_inst[l], l_opa[l]);
		pc  = tk ? tgt : l_npc[l];
		mis = l_en[l] && ref_mispredict(tk, tgt, l_pt[l], l_ptg[l]);
	endtask

	task automatic check_lane(input int lane, input logic en, input logic tk, input logic mis,
		input logic [63:0] pc, input logic [`ROB_IDX_W-1:0] rob);
		logic                  v_a, t_a, m_a;
		logic [63:0]           p_a;
		logic [`ROB_IDX_W-1:0] r_a;
		v_a = lane ? valid1_o : valid0_o;
		t_a = lane ? taken1_o : taken0_o;
		m_a = lane ? mispredict1_o : mispredict0_o;
		p_a = lane ? next_pc1_o : next_pc0_o;
		r_a = lane ? rob_idx1_o : rob_idx0_o;
		compare($sformatf("valid%0d_o", lane), en, v_a);
		if (en)
		begin
			compare($sformatf("taken%0d_o", lane), tk, t_a);
			compare($sformatf("mispredict%0d_o", lane), mis, m_a);
			compare($sformatf("next_pc%0d_o", lane), pc, p_a);
			compare($sformatf("rob_idx%0d_o", lane), rob, r_a);
		end
	endtask

	// All status low and all data zero
	task automatic check_idle();
		compare("valid0_o", 0, valid0_o);
		compare("valid1_o", 0, valid1_o);
		compare("taken0_o", 0, taken0_o);
		compare("taken1_o", 0, taken1_o);
		compare("mispredict0_o", 0, mispredict0_o);
		compare("mispredict1_o", 0, mispredict1_o);
		compare("next_pc0_o", 0, next_pc0_o);
		compare("next_pc1_o", 0, next_pc1_o);
		compare("rob_idx0_o", 0, rob_idx0_o);
		compare("rob_idx1_o", 0, rob_idx1_o);
		compare("redirect_valid_o", 0, redirect_valid_o);
		compare("redirect_pc_o", 0, redirect_pc_o);
		compare("redirect_rob_idx_o", 0, redirect_rob_idx_o);
	endtask

	// One issue checked at cycle 2 and again at cycle 3 for the redirect
	task automatic issue_and_check(input logic [`ROB_IDX_W-1:0] head);
		logic        tk  [2];
		logic        mis [2];
		logic [63:0] pc  [2];
		logic        want;
		int          pick;
		for (int l = 0; l < 2; l++)
			model_lane(l, tk[l], mis[l], pc[l]);
		want = mis[0] | mis[1];
		if (mis[0] && mis[1])
			pick = (rob_age(l_rob[1], head) < rob_age(l_rob[0], head)) ? 1 : 0;
		else
			pick = mis[1] ? 1 : 0;
		@(posedge clk);
		#1;
		rob_head_i = head;
		drive_lanes();
		@(posedge clk);
		#1;
		start0_i = 1'b0;
		start1_i = 1'b0;
		@(posedge clk);
		@(negedge clk);
		for (int l = 0; l < 2; l++)
			check_lane(l, l_en[l], tk[l], mis[l], pc[l], l_rob[l]);
		@(posedge clk);
		@(negedge clk);
		compare("redirect_valid_o", want, redirect_valid_o);
		if (want)
		begin
			compare("redirect_pc_o", pc[pick], redirect_pc_o);
			compare("redirect_rob_idx_o", l_rob[pick], redirect_rob_idx_o);
		end
		clear_lanes();
	endtask

	// Eight conditions on edge and random register values
	task automatic test_conditions();
		logic [63:0] vals [6];
		logic [31:0] w;
		vals[0] = 64'd0;
		vals[1] = 64'd1;
		vals[2] = 64'h8000_0000_0000_0000;  // Most negative
		vals[3] = '1;                       // Minus one
		for (int f = 0; f < 8; f++)
		begin
			vals[4] = rand64();
			vals[5] = rand64();
			for (int v = 0; v < 6; v++)
			begin
				w = $urandom;
				set_lane(0, {3'b111, 3'(f), w[25:0]}, rand64() & ~64'h3, vals[v], rand64(),
					`ROB_IDX_W'(f * 6 + v), 1'($urandom % 2), rand64());
				issue_and_check('0);
			end
		end
		end_test("conditions");
	endtask

	task automatic test_targets();
		logic [63:0] npc;
		npc = 64'h0000_0001_2000_0100;
		set_lane(0, {6'h39, 5'd1, 21'h000123}, npc, 64'd0, 64'd0, 1, 1'b0, 64'd0);   // BEQ forward
		issue_and_check(0);
		set_lane(0, {6'h3d, 5'd2, 21'h1ffff0}, npc, 64'd5, 64'd0, 2, 1'b0, 64'd0);   // BNE back
		issue_and_check(0);
		set_lane(0, {6'h3e, 5'd3, 21'h000040}, npc, '1, 64'd0, 3, 1'b0, 64'd0);      // BGE falls through
		issue_and_check(0);
		set_lane(0, {`BR_INST, 5'd31, 21'h0abcde}, npc, 64'd0, 64'd0, 4, 1'b0, 64'd0);
		issue_and_check(0);
		set_lane(0, {`BSR_INST, 5'd26, 21'h100000}, npc, 64'd0, 64'd0, 5, 1'b0, 64'd0);
		issue_and_check(0);
		// JMP, JSR, RET, JSR_CO with low target bits set
		for (int j = 0; j < 4; j++)
		begin
			set_lane(0, {`JMP_GRP, 5'd26, 5'd27, 2'(j), 14'h0}, npc, 64'd0,
				64'h0000_0000_4000_1000 + 64'(j * 64 + 1 + j % 3), `ROB_IDX_W'(6 + j),
				1'b0, 64'd0);
			issue_and_check(0);
		end
		end_test("targets");
	endtask

	task automatic test_mispredict();
		logic [31:0] beq;
		logic [63:0] npc;
		logic [63:0] tgt;
		beq = {6'h39, 5'd4, 21'h000020};
		npc = 64'h0000_0000_0010_0004;
		tgt = ref_target(beq, npc, 64'd0);
		set_lane(0, beq, npc, 64'd0, 64'd0, 8, 1'b1, tgt);         // Correct guess
		issue_and_check(0);
		set_lane(0, beq, npc, 64'd0, 64'd0, 9, 1'b0, tgt);         // Wrong direction
		issue_and_check(0);
		set_lane(0, beq, npc, 64'd0, 64'd0, 10, 1'b1, tgt + 4);    // Wrong target
		issue_and_check(0);
		set_lane(0, {6'h3d, 5'd4, 21'h000020}, npc, 64'd0, 64'd0, 11, 1'b1, tgt);  // Not taken
		issue_and_check(0);
		set_lane(1, {`JMP_GRP, 5'd26, 5'd27, 2'd0, 14'h0}, npc, 64'd0, 64'h7777_0000, 12,
			1'b0, 64'd0);
		issue_and_check(0);
		end_test("mispredict");
	endtask

	// Both lanes mispredict and the older ROB entry must win
	task automatic pair_case(input logic [`ROB_IDX_W-1:0] r0, input logic [`ROB_IDX_W-1:0] r1,
		input logic [`ROB_IDX_W-1:0] head);
		set_lane(0, {`JMP_GRP, 5'd26, 5'd27, 2'd0, 14'h0}, 64'h100, 64'd0, 64'h0000_aaa0, r0,
			1'b0, 64'd0);
		set_lane(1, {`JMP_GRP, 5'd26, 5'd27, 2'd0, 14'h0}, 64'h200, 64'd0, 64'h0000_bbb0, r1,
			1'b0, 64'd0);
		issue_and_check(head);
	endtask

	task automatic test_oldest();
		pair_case(3, 7, 0);
		pair_case(9, 4, 2);
		pair_case(30, 1, 28);  // Wraps with lane 0 older
		pair_case(2, 29, 27);  // Wraps with lane 1 older
		pair_case(0, 31, 0);
		end_test("redirect selection");
	endtask

	task automatic random_lane(input int lane, input logic [`ROB_IDX_W-1:0] rob);
		logic [31:0] w;
		logic [5:0]  op;
		logic [63:0] npc;
		logic [63:0] opa;
		logic [63:0] opb;
		logic [63:0] tgt;
		w = $urandom;
		case ($urandom % 4)
			0: op = 6'h38 | 6'($urandom % 8);
			1: op = `BR_INST;
			2: op = `BSR_INST;
			default: op = `JMP_GRP;
		endcase
		npc = rand64() & ~64'h3;
		opa = ($urandom % 4 == 0) ? 64'd0 : rand64();  // Zero now and then
		opb = rand64();
		tgt = ref_target({op, w[25:0]}, npc, opb);
		set_lane(lane, {op, w[25:0]}, npc, opa, opb, rob, 1'($urandom % 2),
			($urandom % 2) ? tgt : rand64());
	endtask

	task automatic test_pipeline();
		rob_head_i = '0;
		for (int k = 0; k < PIPE_LEN + 2; k++)
		begin
			@(posedge clk);
			#1;
			if (k < PIPE_LEN)
			begin
				random_lane(0, `ROB_IDX_W'(2 * k));
				random_lane(1, `ROB_IDX_W'(2 * k + 1));
				for (int l = 0; l < 2; l++)
				begin
					model_lane(l, e_tk[l][k], e_mis[l][k], e_pc[l][k]);
					e_rob[l][k] = l_rob[l];
				end
				drive_lanes();
			end
			else
			begin
				start0_i = 1'b0;
				start1_i = 1'b0;
			end
			@(negedge clk);
			// Results of the branch issued two loops back
			if (k >= 2)
				for (int l = 0; l < 2; l++)
					check_lane(l, 1'b1, e_tk[l][k-2], e_mis[l][k-2], e_pc[l][k-2], e_rob[l][k-2]);
		end
		clear_lanes();
		end_test("pipelining");
	endtask

	// Reset with mispredicting branches still in flight
	task automatic test_reset();
		pair_case_setup();
		@(posedge clk);
		#1;
		rob_head_i = '0;
		drive_lanes();
		@(posedge clk);
		#1;
		start0_i = 1'b0;
		start1_i = 1'b0;
		rst      = 1'b1;
		repeat (5) @(posedge clk);
		#1;
		rst = 1'b0;
		@(negedge clk);
		check_idle();
		repeat (3) @(posedge clk);
		@(negedge clk);
		check_idle();
		clear_lanes();
		end_test("reset");
	endtask

	task automatic pair_case_setup();
		set_lane(0, {`JMP_GRP, 5'd26, 5'd27, 2'd0, 14'h0}, 64'h100, 64'd0, 64'h1230, 1,
			1'b0, 64'd0);
		set_lane(1, {`BR_INST, 5'd31, 21'h000010}, 64'h200, 64'd0, 64'd0, 2, 1'b0, 64'd0);
	endtask

	initial
	begin
		seed_val = $urandom(32'hcc7e_ede2);
		checks   = 0;
		errors   = 0;
		chk_mark = 0;
		err_mark = 0;
		clk      = 1'b0;
		rst      = 1'b1;
		rob_head_i = '0;
		clear_lanes();
		drive_lanes();  // Every lane input starts at zero
		repeat (5) @(posedge clk);
		#1;
		rst = 1'b0;
		@(negedge clk);
		check_idle();
		end_test("initial reset");
		test_conditions();
		test_targets();
		test_mispredict();
		test_oldest();
		test_pipeline();
		test_reset();
		$display("Summary: %0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

	// Watchdog sized from the test lengths
	initial
	begin
		#(LIMIT_NS);
		$display("Timeout: tests still running after %0d ns", LIMIT_NS);
		$display("Result: FAILED");
		$finish;
	end

endmodule

// File: tb.f
+incdir+.
br_pkg.sv
brcond.sv
br_alu.sv
br_resolve.sv
br_redirect.sv
br_unit.sv
tb_br_unit.sv

// File: Bender.yml
package:
  name: br_unit

export_include_dirs:
  - .

sources:
  - files:
      - br_pkg.sv
      - brcond.sv
      - br_alu.sv
      - br_resolve.sv
      - br_redirect.sv
      - br_unit.sv
  - target: test
    files:
      - tb_br_unit.sv
